// ==== Makefile ====
# Verilator build and run for the issue stage testbench

VERILATOR ?= verilator
TOP       ?= tb_issue
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation FAILED

SHELL := /bin/bash
BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	set -o pipefail; ./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== issue_chk.sv ====
// Issue slice checker: hazard-free issue, stable stalled dispatch and idle outputs in reset
`timescale 1ns/1ps
`default_nettype none

module issue_chk #(
    parameter int  NX        = 2,
    parameter int  NUM_WARPS = 4,
    localparam int WID_W     = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                ibuf_pop,
    input  issue_pkg::dispatch_instr_t          pop_rec,
    input  logic                                wb_valid,
    input  logic [WID_W-1:0]                    wb_wid,
    input  issue_pkg::reg_idx_t                 wb_rd,
    input  logic [NX-1:0]                       disp_valid,
    input  logic [NX-1:0]                       disp_ready,
    input  issue_pkg::dispatch_instr_t [NX-1:0] disp_instr
);

    logic [NUM_WARPS-1:0][issue_pkg::num_regs_c-1:0] in_flight;
    issue_pkg::decode_instr_t                        pop_instr;
    logic [WID_W-1:0]                                pop_wid;
    logic                                            hazard;

    assign pop_instr = pop_rec.instr;
    assign pop_wid   = WID_W'(pop_rec.wid);

    // Writes in flight per full warp id, tracked from the issued records and the writebacks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= '0;
        end else begin
            if (wb_valid) begin
                in_flight[wb_wid][wb_rd] <= 1'b0;
            end
            if (ibuf_pop && pop_instr.wb && (pop_instr.rd != '0)) begin
                in_flight[pop_wid][pop_instr.rd] <= 1'b1;
            end
        end
    end

    assign hazard = in_flight[pop_wid][pop_instr.rs1] || in_flight[pop_wid][pop_instr.rs2] ||
                    (pop_instr.wb && in_flight[pop_wid][pop_instr.rd]);

    // The head may only leave the buffer when none of its registers awaits a writeback
    a_pop_hazard_free: assert property (@(posedge clk) disable iff (!arst_n)
        ibuf_pop |-> !hazard)
        else $error("Buffer head left the slice while one of its registers was pending");

    for (genvar u = 0; u < NX; u++) begin : g_unit
        a_disp_stable: assert property (@(posedge clk) disable iff (!arst_n)
            (disp_valid[u] && !disp_ready[u]) |=> (disp_valid[u] && $stable(disp_instr[u])))
            else $error("Dispatch on unit %0d dropped or changed while stalled", u);
    end

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> (disp_valid == '0))
        else $error("Dispatch valid was high during reset");

endmodule

bind issue_slice issue_chk #(
    .NX        (issue_pkg::num_ex_units_c),
    .NUM_WARPS (NUM_WARPS)
) i_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .ibuf_pop   (ibuf_pop),
    .pop_rec    (disp_rec),
    .wb_valid   (wb_valid),
    .wb_wid     (wb_wid),
    .wb_rd      (wb_rd),
    .disp_valid (disp_valid),
    .disp_ready (disp_ready),
    .disp_instr (disp_instr)
);

`default_nettype wire

// ==== issue_decode_if.sv ====
// Decoded-instruction stream between the issue router and one issue slice
`timescale 1ns/1ps
`default_nettype none

interface issue_decode_if #(
    parameter int NUM_WARPS = 4
) ();

    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;

    logic                    valid;
    logic                    ready;
    logic [WID_W-1:0]        wid;
    issue_pkg::decode_instr_t instr;

    // The router is the source, the slice is the sink
    modport source (
        output valid, wid, instr,
        input  ready
    );

    modport sink (
        input  valid, wid, instr,
        output ready
    );

endinterface

`default_nettype wire

// ==== issue_dispatch_demux.sv ====
// Dispatch demux: queues an issued instruction in front of its execution unit
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch_demux #(
    parameter int NUM_WARPS = 4,
    parameter int EXQ_DEPTH = 2
) (
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    input  logic                                                  in_valid,
    input  issue_pkg::dispatch_instr_t                            in_instr,
    output logic                                                  in_ready,
    output logic [issue_pkg::num_ex_units_c-1:0]                  out_valid,
    output issue_pkg::dispatch_instr_t [issue_pkg::num_ex_units_c-1:0] out_instr,
    input  logic [issue_pkg::num_ex_units_c-1:0]                  out_ready
);

    localparam int NX = issue_pkg::num_ex_units_c;

    logic [NX-1:0] q_valid;
    logic [NX-1:0] q_ready;

    for (genvar u = 0; u < NX; u++) begin : g_exq
        assign q_valid[u] = in_valid && (in_instr.instr.ex_unit == issue_pkg::ex_unit_e'(u));

        issue_fifo #(
            .T     (issue_pkg::dispatch_instr_t),
            .DEPTH (EXQ_DEPTH)
        ) i_exq (
            .clk       (clk),
            .arst_n    (arst_n),
            .in_valid  (q_valid[u]),
            .in_data   (in_instr),
            .in_ready  (q_ready[u]),
            .out_valid (out_valid[u]),
            .out_data  (out_instr[u]),
            .out_ready (out_ready[u])
        );
    end

    // A full queue only holds back instructions bound for its own unit
    assign in_ready = q_ready[in_instr.instr.ex_unit];

endmodule

`default_nettype wire

// ==== issue_fifo.sv ====
// Synchronous FIFO with a type-parameterized payload and valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module issue_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic arst_n,
    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,
    output logic out_valid,
    output T     out_data,
    input  logic out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Neither flag looks at the far side, so no combinational path crosses the FIFO
    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Count is unchanged when one entry enters and one leaves together
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== issue_pkg.sv ====
// Issue stage package: instruction records, execution unit codes and warp-to-slice mapping
`default_nettype none

package issue_pkg;

    localparam int num_regs_c     = 32;
    localparam int num_ex_units_c = 2;

    // Dispatched records carry the warp id at a fixed width, wide enough for any core size
    localparam int wid_w_c = 8;

    typedef logic [4:0]         reg_idx_t;
    typedef logic [wid_w_c-1:0] wid_t;

    typedef enum logic {
        ex_alu = 1'b0,
        ex_lsu = 1'b1
    } ex_unit_e;

    typedef struct packed {
        ex_unit_e   ex_unit;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic       wb;
        logic [7:0] tag;
    } decode_instr_t;

    typedef struct packed {
        wid_t          wid;
        decode_instr_t instr;
    } dispatch_instr_t;

    // Warps are interleaved over the slices, so neighbouring warps land on different slices
    function automatic int unsigned wid_to_slice(int unsigned wid, int unsigned issue_width);
        return wid % issue_width;
    endfunction

    function automatic int unsigned wid_to_local(int unsigned wid, int unsigned issue_width);
        return wid / issue_width;
    endfunction

endpackage

`default_nettype wire

// ==== issue_router.sv ====
// Issue router: steers each decoded instruction to the slice that owns its warp
`timescale 1ns/1ps
`default_nettype none

module issue_router #(
    parameter int  NUM_WARPS   = 4,
    parameter int  ISSUE_WIDTH = 2,
    localparam int WID_W       = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  logic [WID_W-1:0]                  in_wid,
    input  issue_pkg::decode_instr_t          in_instr,
    output logic                              in_ready,
    issue_decode_if.source                    slice_if [ISSUE_WIDTH]
);

    localparam int SLICE_W = (ISSUE_WIDTH > 1) ? $clog2(ISSUE_WIDTH) : 1;

    logic [SLICE_W-1:0]     sel;
    logic [ISSUE_WIDTH-1:0] slice_ready;

    assign sel = SLICE_W'(issue_pkg::wid_to_slice(32'(in_wid), ISSUE_WIDTH));

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slice
        // Payload goes to every slice, only the owner sees valid
        assign slice_if[i].valid = in_valid && (sel == SLICE_W'(i));
        assign slice_if[i].wid   = in_wid;
        assign slice_if[i].instr = in_instr;
        assign slice_ready[i]    = slice_if[i].ready;
    end

    // A full slice stalls only the warps it owns
    assign in_ready = slice_ready[sel];

endmodule

`default_nettype wire

// ==== issue_scoreboard.sv ====
// Register scoreboard: pending-write bits per local warp, set on issue and cleared on writeback
`timescale 1ns/1ps
`default_nettype none

module issue_scoreboard #(
    parameter int  NUM_WARPS   = 4,
    parameter int  ISSUE_WIDTH = 2,
    localparam int PER_SLICE   = (NUM_WARPS + ISSUE_WIDTH - 1) / ISSUE_WIDTH,
    localparam int LW_W        = (PER_SLICE > 1) ? $clog2(PER_SLICE) : 1
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [LW_W-1:0]          chk_local,
    input  issue_pkg::decode_instr_t chk_instr,
    input  logic                     set_valid,
    input  logic                     wb_valid,
    input  logic [LW_W-1:0]          wb_local,
    input  issue_pkg::reg_idx_t      wb_rd,
    output logic                     clear
);

    logic [PER_SLICE-1:0][issue_pkg::num_regs_c-1:0] pending;
    logic [issue_pkg::num_regs_c-1:0]                warp_pend;
    logic                                            rs1_busy;
    logic                                            rs2_busy;
    logic                                            rd_busy;
    logic                                            do_set;

    assign warp_pend = pending[chk_local];

    // Sources block read-after-write, the destination blocks write-after-write
    assign rs1_busy = warp_pend[chk_instr.rs1];
    assign rs2_busy = warp_pend[chk_instr.rs2];
    assign rd_busy  = chk_instr.wb && warp_pend[chk_instr.rd];

    assign clear = !rs1_busy && !rs2_busy && !rd_busy;

    // Register 0 is hardwired, writes to it never become pending
    assign do_set = set_valid && chk_instr.wb && (chk_instr.rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            if (wb_valid) begin
                pending[wb_local][wb_rd] <= 1'b0;
            end
            // Placed after the clear, so a new producer of the same register stays pending
            if (do_set) begin
                pending[chk_local][chk_instr.rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== issue_slice.sv ====
// Issue slice: in-order instruction buffer, hazard scoreboard and per-unit dispatch queues
`timescale 1ns/1ps
`default_nettype none

module issue_slice #(
    parameter int  NUM_WARPS   = 4,
    parameter int  ISSUE_WIDTH = 2,
    parameter int  IBUF_DEPTH  = 4,
    parameter int  EXQ_DEPTH   = 2,
    parameter int  SLICE_ID    = 0,
    localparam int WID_W       = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    issue_decode_if.sink                                          dec_if,
    input  logic                                                  wb_valid,
    input  logic [WID_W-1:0]                                      wb_wid,
    input  issue_pkg::reg_idx_t                                   wb_rd,
    input  logic [issue_pkg::num_ex_units_c-1:0]                  disp_ready,
    output logic [issue_pkg::num_ex_units_c-1:0]                  disp_valid,
    output issue_pkg::dispatch_instr_t [issue_pkg::num_ex_units_c-1:0] disp_instr
);

    localparam int PER_SLICE = (NUM_WARPS + ISSUE_WIDTH - 1) / ISSUE_WIDTH;
    localparam int LW_W      = (PER_SLICE > 1) ? $clog2(PER_SLICE) : 1;

    typedef struct packed {
        logic [LW_W-1:0]          lwid;
        issue_pkg::decode_instr_t instr;
    } ibuf_entry_t;

    ibuf_entry_t                ibuf_in;
    ibuf_entry_t                head;
    logic                       head_valid;
    logic                       head_ready;
    logic                       sb_clear;
    logic                       ibuf_pop;
    logic                       demux_valid;
    logic                       demux_ready;
    issue_pkg::dispatch_instr_t disp_rec;
    logic [LW_W-1:0]            wb_local;

    assign ibuf_in.lwid  = LW_W'(issue_pkg::wid_to_local(32'(dec_if.wid), ISSUE_WIDTH));
    assign ibuf_in.instr = dec_if.instr;

    issue_fifo #(
        .T     (ibuf_entry_t),
        .DEPTH (IBUF_DEPTH)
    ) i_ibuf (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (dec_if.valid),
        .in_data   (ibuf_in),
        .in_ready  (dec_if.ready),
        .out_valid (head_valid),
        .out_data  (head),
        .out_ready (head_ready)
    );

    assign wb_local = LW_W'(issue_pkg::wid_to_local(32'(wb_wid), ISSUE_WIDTH));

    issue_scoreboard #(
        .NUM_WARPS   (NUM_WARPS),
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) i_scoreboard (
        .clk       (clk),
        .arst_n    (arst_n),
        .chk_local (head.lwid),
        .chk_instr (head.instr),
        .set_valid (ibuf_pop),
        .wb_valid  (wb_valid),
        .wb_local  (wb_local),
        .wb_rd     (wb_rd),
        .clear     (sb_clear)
    );

    // The head is offered only when hazard free, so valid never waits on ready
    assign demux_valid = head_valid && sb_clear;
    assign head_ready  = sb_clear && demux_ready;
    assign ibuf_pop    = head_valid && head_ready;

    // Slices own warps SLICE_ID, SLICE_ID + ISSUE_WIDTH and so on
    assign disp_rec.wid   = issue_pkg::wid_t'(32'(head.lwid) * ISSUE_WIDTH + SLICE_ID);
    assign disp_rec.instr = head.instr;

    issue_dispatch_demux #(
        .NUM_WARPS (NUM_WARPS),
        .EXQ_DEPTH (EXQ_DEPTH)
    ) i_dispatch_demux (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (demux_valid),
        .in_instr  (disp_rec),
        .in_ready  (demux_ready),
        .out_valid (disp_valid),
        .out_instr (disp_instr),
        .out_ready (disp_ready)
    );

endmodule

`default_nettype wire

// ==== issue_stim.txt ====
# wid ex_unit rd rs1 rs2 wb tag exp_slice exp_unit
# ex_unit 0 is ALU and 1 is LSU, tag is hex, all other columns decimal
0 0 1 2 3 1 01 0 0
1 0 4 5 6 1 02 1 0
0 0 2 1 1 1 03 0 0
1 1 7 4 0 1 04 1 1
2 0 1 3 3 1 05 0 0
3 1 0 8 9 0 06 1 1
0 1 5 2 0 1 07 0 1
2 0 1 1 1 1 08 0 0
1 0 4 7 7 1 09 1 0
3 0 3 3 3 1 0a 1 0
0 0 6 5 2 1 0b 0 0
2 1 9 1 0 1 0c 0 1
1 1 0 4 1 0 0d 1 1
3 0 3 3 0 1 0e 1 0
0 0 1 6 0 1 0f 0 0
2 0 2 9 1 1 10 0 0
1 0 8 0 0 1 11 1 0
3 1 10 3 0 1 12 1 1
0 0 7 1 1 1 13 0 0
2 0 0 2 2 1 14 0 0
1 1 11 8 4 1 15 1 1
3 0 12 10 3 1 16 1 0
0 1 0 7 0 0 17 0 1
2 0 3 2 3 1 18 0 0

// ==== issue_top.sv ====
// Issue stage top: decode router, one issue slice per lane and unit-major dispatch ports
`timescale 1ns/1ps
`default_nettype none

module issue_top #(
    parameter int  NUM_WARPS   = 4,
    parameter int  ISSUE_WIDTH = 2,
    parameter int  IBUF_DEPTH  = 4,
    parameter int  EXQ_DEPTH   = 2,
    localparam int WID_W       = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1,
    localparam int NX          = issue_pkg::num_ex_units_c
) (
    input  logic                                               clk,
    input  logic                                               arst_n,
    input  logic                                               dec_valid,
    input  logic [WID_W-1:0]                                   dec_wid,
    input  issue_pkg::decode_instr_t                           dec_instr,
    output logic                                               dec_ready,
    input  logic [ISSUE_WIDTH-1:0]                             wb_valid,
    input  logic [ISSUE_WIDTH-1:0][WID_W-1:0]                  wb_wid,
    input  issue_pkg::reg_idx_t [ISSUE_WIDTH-1:0]              wb_rd,
    input  logic [NX*ISSUE_WIDTH-1:0]                          disp_ready,
    output logic [NX*ISSUE_WIDTH-1:0]                          disp_valid,
    output issue_pkg::dispatch_instr_t [NX*ISSUE_WIDTH-1:0]    disp_instr
);

    issue_decode_if #(.NUM_WARPS(NUM_WARPS)) slice_if [ISSUE_WIDTH] ();

    issue_router #(
        .NUM_WARPS   (NUM_WARPS),
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) i_router (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (dec_valid),
        .in_wid   (dec_wid),
        .in_instr (dec_instr),
        .in_ready (dec_ready),
        .slice_if (slice_if)
    );

    for (genvar s = 0; s < ISSUE_WIDTH; s++) begin : g_slice
        logic [NX-1:0]                       s_disp_ready;
        logic [NX-1:0]                       s_disp_valid;
        issue_pkg::dispatch_instr_t [NX-1:0] s_disp_instr;

        issue_slice #(
            .NUM_WARPS   (NUM_WARPS),
            .ISSUE_WIDTH (ISSUE_WIDTH),
            .IBUF_DEPTH  (IBUF_DEPTH),
            .EXQ_DEPTH   (EXQ_DEPTH),
            .SLICE_ID    (s)
        ) i_slice (
            .clk        (clk),
            .arst_n     (arst_n),
            .dec_if     (slice_if[s]),
            .wb_valid   (wb_valid[s]),
            .wb_wid     (wb_wid[s]),
            .wb_rd      (wb_rd[s]),
            .disp_ready (s_disp_ready),
            .disp_valid (s_disp_valid),
            .disp_instr (s_disp_instr)
        );

        // Unit-major layout: port index is unit times ISSUE_WIDTH plus slice
        for (genvar u = 0; u < NX; u++) begin : g_unit
            assign s_disp_ready[u]                = disp_ready[u*ISSUE_WIDTH + s];
            assign disp_valid[u*ISSUE_WIDTH + s]  = s_disp_valid[u];
            assign disp_instr[u*ISSUE_WIDTH + s]  = s_disp_instr[u];
        end
    end

endmodule

`default_nettype wire

// ==== tb_issue.sv ====
// Issue stage testbench: file-driven decode stream, execution unit model with writeback, order checks
`timescale 1ns/1ps
`default_nettype none

module tb_issue;

    localparam int NW        = 4;
    localparam int IW        = 2;
    localparam int NX        = issue_pkg::num_ex_units_c;
    localparam int NP        = NX * IW;
    localparam int WID_W     = 2;
    localparam int MAX_LINES = 64;
    // ALU port of slice 0 is held off for this window of cycles
    localparam int BP_START  = 16;
    localparam int BP_END    = 56;

    logic                                clk;
    logic                                arst_n;
    logic                                dec_valid;
    logic [WID_W-1:0]                    dec_wid;
    issue_pkg::decode_instr_t            dec_instr;
    logic                                dec_ready;
    logic [IW-1:0]                       wb_valid;
    logic [IW-1:0][WID_W-1:0]            wb_wid;
    issue_pkg::reg_idx_t [IW-1:0]        wb_rd;
    logic [NP-1:0]                       disp_ready;
    logic [NP-1:0]                       disp_valid;
    issue_pkg::dispatch_instr_t [NP-1:0] disp_instr;

    int                       stim_wid [MAX_LINES];
    issue_pkg::decode_instr_t stim_instr [MAX_LINES];
    int                       n_lines;
    int                       exp_idx [NP][$];
    int                       wb_due [IW][$];
    int                       wb_w [IW][$];
    int                       wb_r [IW][$];
    int                       cycle;
    int                       limit;
    int                       mism_cnt;
    int                       other_cnt;
    int                       disp_cnt;
    int                       other_in_bp;
    integer                   seed;

    issue_top #(
        .NUM_WARPS   (NW),
        .ISSUE_WIDTH (IW),
        .IBUF_DEPTH  (4),
        .EXQ_DEPTH   (2)
    ) i_issue_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .dec_valid  (dec_valid),
        .dec_wid    (dec_wid),
        .dec_instr  (dec_instr),
        .dec_ready  (dec_ready),
        .wb_valid   (wb_valid),
        .wb_wid     (wb_wid),
        .wb_rd      (wb_rd),
        .disp_ready (disp_ready),
        .disp_valid (disp_valid),
        .disp_instr (disp_instr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_val(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            mism_cnt++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures", mism_cnt, other_cnt);
        if (mism_cnt == 0 && other_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic load_stim();
        int    fd;
        int    rc;
        string line;
        int    f_wid;
        int    f_unit;
        int    f_rd;
        int    f_rs1;
        int    f_rs2;
        int    f_wb;
        int    f_tag;
        int    f_slice;
        int    f_xu;
        fd = $fopen("issue_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file issue_stim.txt");
            other_cnt++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Comment lines and blank lines carry no instruction
            if (line.len() > 1 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%d %d %d %d %d %d %h %d %d", f_wid, f_unit, f_rd,
                             f_rs1, f_rs2, f_wb, f_tag, f_slice, f_xu);
                if (rc != 9 || n_lines >= MAX_LINES) begin
                    $display("Stimulus line could not be used: %s", line);
                    other_cnt++;
                end else if (f_slice < 0 || f_slice >= IW || f_xu < 0 || f_xu >= NX) begin
                    $display("Stimulus line names a slice or unit that does not exist: %s", line);
                    other_cnt++;
                end else begin
                    stim_wid[n_lines]           = f_wid;
                    stim_instr[n_lines].ex_unit = issue_pkg::ex_unit_e'(f_unit[0]);
                    stim_instr[n_lines].rd      = 5'(f_rd);
                    stim_instr[n_lines].rs1     = 5'(f_rs1);
                    stim_instr[n_lines].rs2     = 5'(f_rs2);
                    stim_instr[n_lines].wb      = f_wb[0];
                    stim_instr[n_lines].tag     = 8'(f_tag);
                    // Warps interleave over slices, so the owner is wid modulo the width
                    check_val("stim_slice", f_wid % IW, f_slice);
                    check_val("stim_unit", f_unit, f_xu);
                    exp_idx[f_xu*IW + f_slice].push_back(n_lines);
                    n_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Port p is unit p / IW of slice p % IW
    task automatic record_dispatch(input int p);
        issue_pkg::dispatch_instr_t d;
        int                         s;
        int                         r;
        int                         idx;
        d = disp_instr[p];
        s = p % IW;
        disp_cnt++;
        check_val("route_slice", s, int'(d.wid) % IW);
        check_val("route_unit", p / IW, int'(d.instr.ex_unit));
        if (exp_idx[p].size() == 0) begin
            $display("Tag %0h was dispatched on unit %0d of slice %0d with none expected there",
                     d.instr.tag, p / IW, s);
            other_cnt++;
        end else begin
            idx = exp_idx[p].pop_front();
            check_val("order_tag", int'(stim_instr[idx].tag), int'(d.instr.tag));
            check_val("disp_wid", stim_wid[idx], int'(d.wid));
            check_val("disp_fields", int'(stim_instr[idx]), int'(d.instr));
        end
        if (cycle >= BP_START && cycle < BP_END && s != 0) begin
            other_in_bp++;
        end
        if (d.instr.wb) begin
            r = $random(seed);
            wb_due[s].push_back(cycle + 1 + (r & 7));
            wb_w[s].push_back(int'(d.wid));
            wb_r[s].push_back(int'(d.instr.rd));
        end
    endtask

    // Execution units: accept dispatches, return writebacks later, randomize ready
    always @(posedge clk) begin : exec_model
        int r;
        bit fired;
        cycle++;
        if (arst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (disp_valid[p] && disp_ready[p]) begin
                    record_dispatch(p);
                end
            end
            for (int s = 0; s < IW; s++) begin
                fired = 1'b0;
                wb_valid[s] <= 1'b0;
                for (int k = 0; k < wb_due[s].size() && !fired; k++) begin
                    if (wb_due[s][k] <= cycle) begin
                        wb_valid[s] <= 1'b1;
                        wb_wid[s]   <= WID_W'(wb_w[s][k]);
                        wb_rd[s]    <= 5'(wb_r[s][k]);
                        wb_due[s].delete(k);
                        wb_w[s].delete(k);
                        wb_r[s].delete(k);
                        fired = 1'b1;
                    end
                end
            end
            for (int p = 0; p < NP; p++) begin
                r = $random(seed);
                disp_ready[p] <= (r[1:0] != 2'b00);
            end
            if (cycle >= BP_START && cycle < BP_END) begin
                disp_ready[0] <= 1'b0;
            end
        end
        if (cycle >= limit) begin
            $display("Timeout: %0d of %0d instructions dispatched after %0d cycles",
                     disp_cnt, n_lines, cycle);
            other_cnt++;
            finish_run();
        end
    end

    initial begin
        arst_n      = 1'b0;
        dec_valid   = 1'b0;
        dec_wid     = '0;
        dec_instr   = '0;
        wb_valid    = '0;
        wb_wid      = '0;
        wb_rd       = '0;
        disp_ready  = '0;
        seed        = 32'h717;
        cycle       = 0;
        mism_cnt    = 0;
        other_cnt   = 0;
        disp_cnt    = 0;
        other_in_bp = 0;
        n_lines     = 0;
        load_stim();
        if (n_lines == 0) begin
            $display("No instructions were loaded from the stimulus file");
            other_cnt++;
        end
        limit = 40 * n_lines + 200;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_val("reset_dec_ready", 1, int'(dec_ready));
        check_val("reset_disp_valid", 0, int'(disp_valid));
        for (int i = 0; i < n_lines; i++) begin
            dec_valid <= 1'b1;
            dec_wid   <= WID_W'(stim_wid[i]);
            dec_instr <= stim_instr[i];
            @(posedge clk);
            while (!dec_ready) @(posedge clk);
        end
        dec_valid <= 1'b0;
        while (disp_cnt < n_lines) @(posedge clk);
        repeat (10) @(posedge clk);
        check_val("dispatch_count", n_lines, disp_cnt);
        for (int p = 0; p < NP; p++) begin
            check_val("tags_left", 0, exp_idx[p].size());
        end
        if (other_in_bp == 0) begin
            $display("Slice 1 dispatched nothing while the ALU of slice 0 was held off");
            other_cnt++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
issue_pkg.sv
issue_decode_if.sv
issue_fifo.sv
issue_scoreboard.sv
issue_dispatch_demux.sv
issue_router.sv
issue_slice.sv
issue_top.sv
issue_chk.sv
tb_issue.sv
